//--- tb.f
rtl/ingress_geometry_pkg.sv
rtl/ingress_stream_pkg.sv
rtl/ingress_buffer_mem.sv
rtl/ingress_write_ctrl.sv
rtl/ingress_read_sched.sv
rtl/ingress_buffer_top.sv
test/ingress_buffer_assert.sv
test/tb_ingress_buffer.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ingress buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_ingress_buffer

out=$(./obj_dir/Vtb_ingress_buffer)
echo "$out"

if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1

//--- test/tb_ingress_buffer.sv
//////////////////////////////////////////////////////////////////////
// Ingress buffer testbench
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_ingress_buffer
    import ingress_geometry_pkg::*;
    import ingress_stream_pkg::*;
();

    localparam int timeout_cycles = 2000;

    logic         ing_bus = 1'b0;
    logic         rst_n;
    in_beat_arr_t in_beat;
    logic [3:0]   in_valid;
    logic [3:0]   in_ready;
    out_beat_t    out_beat;
    logic         out_valid;
    logic         out_ready;
    logic [3:0]   overflow;

    // Output ready is either a level or a pre-drawn random pattern
    logic         ready_level;
    logic         ready_rand_en;
    logic [255:0] ready_pat;
    logic [7:0]   ready_idx = 8'd0;

    in_beat_t  tx_q [num_ports][$];
    out_beat_t exp_q [num_ports][$];
    int        rx_cnt [num_ports];
    int        ovf_count [num_ports];
    int        ovf_expected [num_ports];
    int        mon_errors;
    int        errors;
    int        tests_run;
    int        tests_failed;
    int        seed = 32'h8c8f;

    always #5 ing_bus = ~ing_bus;

    ingress_buffer_top dut0 (
        .ing_bus   (ing_bus),
        .rst_n     (rst_n),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .overflow  (overflow)
    );

    assign out_ready = ready_rand_en ? ready_pat[ready_idx] : ready_level;

    always @(posedge ing_bus) begin
        #1;
        ready_idx = ready_idx + 8'd1;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed) & 32'h7fffffff;
        return r % n;
    endfunction

    // Last keep from the byte length, all ones for a whole word
    function automatic keep_t keep_for_len(input byte_len_t len);
        int r;
        r = int'(len) % data_bytes;
        return (r == 0) ? '1 : keep_t'((9'd1 << r) - 9'd1);
    endfunction

    function automatic int pending_beats();
        int n;
        n = 0;
        for (int i = 0; i < num_ports; i++) begin
            n = n + exp_q[port_id_t'(i)].size() - rx_cnt[port_id_t'(i)];
        end
        return n;
    endfunction

    function automatic int total_errors();
        return errors + mon_errors;
    endfunction

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] want);
        $display("error %s: got %h expected %h", name, got, want);
    endtask

    // Queue the input beats and, unless dropped, the expected output
    task automatic build_packet(input port_id_t port, input int nwords, input int nlast,
                                input bit expect_out);
        in_beat_t    b;
        out_beat_t   e;
        byte_len_t   len;
        logic [31:0] hi;
        logic [31:0] lo;
        len = byte_len_t'(8 * (nwords - 1) + nlast);
        for (int w = 0; w < nwords; w++) begin
            hi = $random(seed);
            lo = $random(seed);
            b.data = {hi, lo};
            b.last = (w == nwords - 1);
            b.keep = b.last ? keep_t'((9'd1 << nlast) - 9'd1) : '1;
            tx_q[port].push_back(b);
            if (expect_out) begin
                e.data          = b.data;
                e.keep          = b.last ? keep_for_len(len) : '1;
                e.last          = b.last;
                e.meta.port     = port;
                e.meta.byte_len = len;
                exp_q[port].push_back(e);
            end
        end
    endtask

    // Present beats until the last one is accepted
    task automatic drive_packet(input port_id_t port);
        in_beat_t b;
        int       waited;
        bit       done;
        done = 1'b0;
        while (!done && tx_q[port].size() > 0) begin
            b = tx_q[port].pop_front();
            in_beat[port]  = b;
            in_valid[port] = 1'b1;
            waited = 0;
            while (!in_ready[port] && waited < timeout_cycles) begin
                @(posedge ing_bus);
                #1;
                waited++;
            end
            if (!in_ready[port]) begin
                $display("timeout waiting for in_ready on port %0d", port);
                errors++;
            end
            @(posedge ing_bus);
            #1;
            in_valid[port] = 1'b0;
            done = b.last;
        end
    endtask

    task automatic drive_packets(input port_id_t port, input int count);
        for (int k = 0; k < count; k++) begin
            drive_packet(port);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (pending_beats() > 0 && waited < timeout_cycles) begin
            @(posedge ing_bus);
            #1;
            waited++;
        end
        if (pending_beats() > 0) begin
            $display("timeout with %0d output beats still missing", pending_beats());
            errors++;
        end
        // Nothing may remain in the output pipeline
        if (out_valid !== 1'b0) begin
            report_value("out_valid", 64'(out_valid), 64'd0);
            errors++;
        end
    endtask

    task automatic close_test(input string name, input int errs_before);
        for (int i = 0; i < num_ports; i++) begin
            if (ovf_count[port_id_t'(i)] != ovf_expected[port_id_t'(i)]) begin
                $display("error overflow[%0d] pulse count: got %h expected %h", i,
                         ovf_count[port_id_t'(i)], ovf_expected[port_id_t'(i)]);
                errors++;
            end
        end
        tests_run++;
        if (total_errors() != errs_before) begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, total_errors() - errs_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output monitor and scoreboard

    task automatic check_beat(input out_beat_t got);
        port_id_t  p;
        out_beat_t want;
        p = got.meta.port;
        if (rx_cnt[p] >= exp_q[p].size()) begin
            $display("unexpected output beat on port %0d with data %h", p, got.data);
            mon_errors++;
        end else begin
            want = exp_q[p][rx_cnt[p]];
            rx_cnt[p]++;
            if (got.data !== want.data) begin
                report_value($sformatf("out_beat.data port %0d", p), got.data, want.data);
                mon_errors++;
            end
            if (got.keep !== want.keep) begin
                report_value($sformatf("out_beat.keep port %0d", p), 64'(got.keep),
                             64'(want.keep));
                mon_errors++;
            end
            if (got.last !== want.last) begin
                report_value($sformatf("out_beat.last port %0d", p), 64'(got.last),
                             64'(want.last));
                mon_errors++;
            end
            if (got.meta.byte_len !== want.meta.byte_len) begin
                report_value($sformatf("out_beat.meta.byte_len port %0d", p),
                             64'(got.meta.byte_len), 64'(want.meta.byte_len));
                mon_errors++;
            end
        end
    endtask

    // Values at the falling edge are those seen by the next rising edge
    always @(negedge ing_bus) begin
        if (rst_n) begin
            for (int i = 0; i < num_ports; i++) begin
                if (overflow[port_id_t'(i)]) begin
                    ovf_count[port_id_t'(i)] = ovf_count[port_id_t'(i)] + 1;
                end
            end
            if (out_valid && out_ready) begin
                check_beat(out_beat);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic single_packet_per_port();
        int errs_before;
        errs_before = total_errors();
        if (out_valid !== 1'b0) begin
            report_value("out_valid", 64'(out_valid), 64'd0);
            errors++;
        end
        if (overflow !== 4'b0000) begin
            report_value("overflow", 64'(overflow), 64'd0);
            errors++;
        end
        // Lengths of 1 to 4 words, last keep of 3 to 6 bytes
        for (int i = 0; i < num_ports; i++) begin
            build_packet(port_id_t'(i), i + 1, i + 3, 1'b1);
        end
        fork
            drive_packets(2'd0, 1);
            drive_packets(2'd1, 1);
            drive_packets(2'd2, 1);
            drive_packets(2'd3, 1);
        join
        wait_drain();
        close_test("single packet per port", errs_before);
    endtask

    task automatic three_packets_per_port();
        int errs_before;
        errs_before = total_errors();
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < num_ports; i++) begin
                build_packet(port_id_t'(i), (i + k) % 4 + 1, 1 + rand_below(8), 1'b1);
            end
        end
        fork
            drive_packets(2'd0, 3);
            drive_packets(2'd1, 3);
            drive_packets(2'd2, 3);
            drive_packets(2'd3, 3);
        join
        wait_drain();
        close_test("three packets per port", errs_before);
    endtask

    task automatic random_backpressure_burst();
        int errs_before;
        errs_before = total_errors();
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < num_ports; i++) begin
                build_packet(port_id_t'(i), 1 + rand_below(3), 1 + rand_below(8), 1'b1);
            end
        end
        for (int n = 0; n < 256; n++) begin
            ready_pat = {ready_pat[254:0], rand_below(2) == 1};
        end
        ready_rand_en = 1'b1;
        fork
            drive_packets(2'd0, 4);
            drive_packets(2'd1, 4);
            drive_packets(2'd2, 4);
            drive_packets(2'd3, 4);
        join
        wait_drain();
        ready_rand_en = 1'b0;
        close_test("random back-pressure burst", errs_before);
    endtask

    task automatic overflow_drop();
        int errs_before;
        int waited;
        errs_before = total_errors();
        ready_level = 1'b0;
        // Second packet cannot fit behind the first one
        build_packet(2'd1, 10, 5, 1'b1);
        build_packet(2'd1, 10, 8, 1'b0);
        ovf_expected[1]++;
        drive_packets(2'd1, 2);
        waited = 0;
        while (ovf_count[1] != ovf_expected[1] && waited < timeout_cycles) begin
            @(posedge ing_bus);
            #1;
            waited++;
        end
        if (ovf_count[1] != ovf_expected[1]) begin
            $display("timeout waiting for the overflow pulse on port 1");
            errors++;
        end
        ready_level = 1'b1;
        wait_drain();
        close_test("overflow drop", errs_before);
    endtask

    task automatic recovery_after_drop();
        int errs_before;
        errs_before = total_errors();
        build_packet(2'd1, 3, 2, 1'b1);
        drive_packets(2'd1, 1);
        wait_drain();
        close_test("recovery after drop", errs_before);
    endtask

    initial begin
        rst_n         = 1'b0;
        in_beat       = '0;
        in_valid      = '0;
        ready_level   = 1'b1;
        ready_rand_en = 1'b0;
        ready_pat     = '1;
        repeat (8) @(posedge ing_bus);
        #1;
        rst_n = 1'b1;

        single_packet_per_port();
        three_packets_per_port();
        random_backpressure_burst();
        overflow_drop();
        recovery_after_drop();

        $display("tests run %0d, tests failed %0d, beats checked %0d, errors %0d",
                 tests_run, tests_failed, rx_cnt.sum(), total_errors());
        if (total_errors() == 0 && tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- test/ingress_buffer_assert.sv
//////////////////////////////////////////////////////////////////////
// Ingress buffer port checks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ingress_buffer_assert
    import ingress_stream_pkg::*;
(
    input logic       ing_bus,
    input logic       rst_n,
    input logic [3:0] in_ready,
    input logic [3:0] overflow,
    input out_beat_t  out_beat,
    input logic       out_valid,
    input logic       out_ready
);

    // Exactly one port owns the write slot
    in_ready_onehot: assert property (
        @(posedge ing_bus) disable iff (!rst_n) $onehot(in_ready)
    ) else $error("in_ready is not one-hot: %h", in_ready);

    overflow_single: assert property (
        @(posedge ing_bus) disable iff (!rst_n) $onehot0(overflow)
    ) else $error("overflow has more than one bit set: %h", overflow);

    // A stalled beat holds until it is taken
    out_hold: assert property (
        @(posedge ing_bus) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_beat)
    ) else $error("out_beat or out_valid changed while stalled");

endmodule

bind ingress_buffer_top ingress_buffer_assert u_assert (
    .ing_bus   (ing_bus),
    .rst_n     (rst_n),
    .in_ready  (in_ready),
    .overflow  (overflow),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
);

//--- rtl/ingress_buffer_top.sv
//////////////////////////////////////////////////////////////////////
// Ingress packet buffer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ingress_buffer_top
    import ingress_geometry_pkg::*;
    import ingress_stream_pkg::*;
(
    input  logic         ing_bus,
    input  logic         rst_n,
    input  in_beat_arr_t in_beat,
    input  logic [3:0]   in_valid,
    output logic [3:0]   in_ready,
    output out_beat_t    out_beat,
    output logic         out_valid,
    input  logic         out_ready,
    output logic [3:0]   overflow
);

    // Pointer exchange between writer and reader
    word_ptr_arr_t rd_word_ptr;
    pkt_ptr_arr_t  wr_pkt_ptr;

    // Memory ports
    logic       wr_en;
    word_addr_t wr_addr;
    data_t      wr_data;
    logic       rd_en;
    word_addr_t rd_addr;
    data_t      rd_data;
    logic       attr_wr_en;
    pkt_addr_t  attr_wr_addr;
    pkt_attr_t  attr_wr_data;
    pkt_addr_t  attr_rd_addr;
    pkt_attr_t  attr_rd_data;

    ingress_write_ctrl u_write_ctrl (
        .ing_bus      (ing_bus),
        .rst_n        (rst_n),
        .in_beat      (in_beat),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .rd_word_ptr  (rd_word_ptr),
        .wr_pkt_ptr   (wr_pkt_ptr),
        .overflow     (overflow),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .attr_wr_en   (attr_wr_en),
        .attr_wr_addr (attr_wr_addr),
        .attr_wr_data (attr_wr_data)
    );

    ingress_read_sched u_read_sched (
        .ing_bus      (ing_bus),
        .rst_n        (rst_n),
        .wr_pkt_ptr   (wr_pkt_ptr),
        .rd_word_ptr  (rd_word_ptr),
        .attr_rd_addr (attr_rd_addr),
        .attr_rd_data (attr_rd_data),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .out_beat     (out_beat),
        .out_valid    (out_valid),
        .out_ready    (out_ready)
    );

    ingress_buffer_mem u_mem (
        .ing_bus      (ing_bus),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .attr_wr_en   (attr_wr_en),
        .attr_wr_addr (attr_wr_addr),
        .attr_wr_data (attr_wr_data),
        .attr_rd_addr (attr_rd_addr),
        .attr_rd_data (attr_rd_data)
    );

endmodule

//--- rtl/ingress_read_sched.sv
//////////////////////////////////////////////////////////////////////
// Ingress read scheduler
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ingress_read_sched
    import ingress_geometry_pkg::*;
    import ingress_stream_pkg::*;
(
    input  logic          ing_bus,
    input  logic          rst_n,
    input  pkt_ptr_arr_t  wr_pkt_ptr,
    output word_ptr_arr_t rd_word_ptr,
    output pkt_addr_t     attr_rd_addr,
    input  pkt_attr_t     attr_rd_data,
    output logic          rd_en,
    output word_addr_t    rd_addr,
    input  data_t         rd_data,
    output out_beat_t     out_beat,
    output logic          out_valid,
    input  logic          out_ready
);

    typedef enum logic {
        POLL,
        READ
    } rd_state_t;

    rd_state_t    state;
    port_id_t     rd_sel;
    pkt_ptr_arr_t rd_pkt_ptr;
    pkt_attr_t    cur_attr;
    logic         pkt_avail;
    logic         word_last;

    // Stage 0 holds the issued address, stage 1 the returned word
    logic       s0_valid;
    logic       s0_last;
    byte_len_t  s0_len;
    port_id_t   s0_port;
    logic       s1_valid;
    logic       s1_last;
    ing_meta_t  s1_meta;
    keep_t      s1_keep;
    keep_t      keep_last;
    logic       adv0;
    logic       adv1;

    assign adv1      = out_ready || !s1_valid;
    assign adv0      = adv1 || !s0_valid;
    assign rd_en     = adv1 && s0_valid;

    assign attr_rd_addr = {rd_sel, rd_pkt_ptr[rd_sel]};
    assign pkt_avail    = (rd_pkt_ptr[rd_sel] != wr_pkt_ptr[rd_sel]);
    assign word_last    = (rd_word_ptr[rd_sel] == cur_attr.last_ptr);

    // Rebuild the last keep from the byte length
    always_comb begin
        keep_last = '0;
        for (int i = 0; i < data_bytes; i++) begin
            if (i < int'(s0_len) % data_bytes) begin
                keep_last[i] = 1'b1;
            end
        end
        if (int'(s0_len) % data_bytes == 0) begin
            keep_last = '1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Polling FSM and stage 0

    always_ff @(posedge ing_bus or negedge rst_n) begin
        if (!rst_n) begin
            state       <= POLL;
            rd_sel      <= '0;
            rd_word_ptr <= '0;
            rd_pkt_ptr  <= '0;
            s0_valid    <= 1'b0;
            s0_last     <= 1'b0;
        end else begin
            case (state)
                POLL: begin
                    if (adv0) begin
                        s0_valid <= 1'b0;
                    end
                    if (pkt_avail) begin
                        state <= READ;
                    end else begin
                        rd_sel <= rd_sel + 1'b1;
                    end
                end
                READ: begin
                    if (adv0) begin
                        s0_valid            <= 1'b1;
                        s0_last             <= word_last;
                        rd_word_ptr[rd_sel] <= rd_word_ptr[rd_sel] + 1'b1;
                        // Packet fully issued, move on to the next port
                        if (word_last) begin
                            rd_pkt_ptr[rd_sel] <= rd_pkt_ptr[rd_sel] + 1'b1;
                            rd_sel             <= rd_sel + 1'b1;
                            state              <= POLL;
                        end
                    end
                end
                default: begin
                    state <= POLL;
                end
            endcase
        end
    end

    always_ff @(posedge ing_bus) begin
        if (state == POLL && pkt_avail) begin
            cur_attr <= attr_rd_data;
        end
        if (state == READ && adv0) begin
            rd_addr <= {rd_sel, rd_word_ptr[rd_sel]};
            s0_len  <= cur_attr.byte_len;
            s0_port <= rd_sel;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 1 and output

    always_ff @(posedge ing_bus or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
        end else if (adv1) begin
            s1_valid <= s0_valid;
            s1_last  <= s0_valid && s0_last;
        end
    end

    always_ff @(posedge ing_bus) begin
        if (rd_en) begin
            s1_meta.port     <= s0_port;
            s1_meta.byte_len <= s0_len;
            s1_keep          <= s0_last ? keep_last : '1;
        end
    end

    assign out_valid     = s1_valid;
    assign out_beat.data = rd_data;
    assign out_beat.keep = s1_keep;
    assign out_beat.last = s1_last;
    assign out_beat.meta = s1_meta;

endmodule

//--- rtl/ingress_write_ctrl.sv
//////////////////////////////////////////////////////////////////////
// Ingress write controller
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ingress_write_ctrl
    import ingress_geometry_pkg::*;
    import ingress_stream_pkg::*;
(
    input  logic          ing_bus,
    input  logic          rst_n,
    input  in_beat_arr_t  in_beat,
    input  logic [3:0]    in_valid,
    output logic [3:0]    in_ready,
    input  word_ptr_arr_t rd_word_ptr,
    output pkt_ptr_arr_t  wr_pkt_ptr,
    output logic [3:0]    overflow,
    output logic          wr_en,
    output word_addr_t    wr_addr,
    output data_t         wr_data,
    output logic          attr_wr_en,
    output pkt_addr_t     attr_wr_addr,
    output pkt_attr_t     attr_wr_data
);

    // Number of valid bytes in a keep mask
    function automatic logic [3:0] keep_bytes(input keep_t keep);
        logic [3:0] n;
        n = 4'd0;
        for (int i = 0; i < data_bytes; i++) begin
            if (keep[i]) begin
                n = n + 4'd1;
            end
        end
        return n;
    endfunction

    // Slot history, index 0 is the port sampled this cycle
    port_id_t [2:0]             slot;

    word_ptr_arr_t              wr_ptr;
    word_ptr_arr_t              wr_ptr_commit;
    word_cnt_t [num_ports-1:0]  wcnt;
    logic [num_ports-1:0]       drop;

    in_beat_t   sel_beat;
    word_ptr_t  sel_next_ptr;

    logic       s0_valid;
    logic       s0_last;
    logic       s0_full;
    data_t      s0_data;
    logic [3:0] s0_nbytes;
    word_cnt_t  s0_wcnt;
    byte_len_t  pkt_len;

    always_comb begin
        for (int p = 0; p < num_ports; p++) begin
            in_ready[p] = (slot[0] == port_id_t'(p));
        end
    end

    assign sel_beat     = in_beat[slot[0]];
    assign sel_next_ptr = wr_ptr[slot[0]] + 1'b1;
    assign pkt_len      = byte_len_t'({s0_wcnt, 3'b000}) + byte_len_t'(s0_nbytes);

    //////////////////////////////////////////////////////////////////////
    // Slot rotation and stage 0 sampling

    always_ff @(posedge ing_bus or negedge rst_n) begin
        if (!rst_n) begin
            slot     <= '0;
            s0_valid <= 1'b0;
            s0_last  <= 1'b0;
            wcnt     <= '0;
        end else begin
            slot     <= {slot[1:0], port_id_t'(slot[0] + 1'b1)};
            s0_valid <= in_valid[slot[0]];
            s0_last  <= sel_beat.last;
            // Words before the last beat of the packet
            if (in_valid[slot[0]]) begin
                if (sel_beat.last) begin
                    wcnt[slot[0]] <= '0;
                end else begin
                    wcnt[slot[0]] <= wcnt[slot[0]] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge ing_bus) begin
        s0_data   <= sel_beat.data;
        s0_nbytes <= keep_bytes(sel_beat.keep);
        s0_wcnt   <= wcnt[slot[0]];
        // Keep one slot free between writer and reader
        s0_full   <= (sel_next_ptr == rd_word_ptr[slot[0]]);
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 1 decision and stage 2 packet pointer

    always_ff @(posedge ing_bus or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            wr_ptr_commit <= '0;
            drop          <= '0;
            wr_en         <= 1'b0;
            attr_wr_en    <= 1'b0;
            overflow      <= '0;
            wr_pkt_ptr    <= '0;
        end else begin
            wr_en      <= 1'b0;
            attr_wr_en <= 1'b0;
            overflow   <= '0;
            if (s0_valid) begin
                if (s0_full || drop[slot[1]]) begin
                    // Discard the whole packet and rewind
                    wr_ptr[slot[1]]   <= wr_ptr_commit[slot[1]];
                    drop[slot[1]]     <= !s0_last;
                    overflow[slot[1]] <= s0_last;
                end else begin
                    wr_en           <= 1'b1;
                    wr_ptr[slot[1]] <= wr_ptr[slot[1]] + 1'b1;
                    if (s0_last) begin
                        attr_wr_en             <= 1'b1;
                        wr_ptr_commit[slot[1]] <= wr_ptr[slot[1]] + 1'b1;
                    end
                end
            end
            // Packet becomes visible once its attribute is written
            if (attr_wr_en) begin
                wr_pkt_ptr[slot[2]] <= wr_pkt_ptr[slot[2]] + 1'b1;
            end
        end
    end

    always_ff @(posedge ing_bus) begin
        wr_addr               <= {slot[1], wr_ptr[slot[1]]};
        wr_data               <= s0_data;
        attr_wr_addr          <= {slot[1], wr_pkt_ptr[slot[1]]};
        attr_wr_data.last_ptr <= wr_ptr[slot[1]];
        attr_wr_data.byte_len <= pkt_len;
    end

endmodule

//--- rtl/ingress_buffer_mem.sv
//////////////////////////////////////////////////////////////////////
// Ingress word and attribute memories
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ingress_buffer_mem
    import ingress_geometry_pkg::*;
    import ingress_stream_pkg::*;
(
    input  logic       ing_bus,
    input  logic       wr_en,
    input  word_addr_t wr_addr,
    input  data_t      wr_data,
    input  logic       rd_en,
    input  word_addr_t rd_addr,
    output data_t      rd_data,
    input  logic       attr_wr_en,
    input  pkt_addr_t  attr_wr_addr,
    input  pkt_attr_t  attr_wr_data,
    input  pkt_addr_t  attr_rd_addr,
    output pkt_attr_t  attr_rd_data
);

    // One partition per port, addressed as {port, pointer}
    data_t     data_mem [num_ports*words_per_port];
    pkt_attr_t attr_mem [num_ports*pkts_per_port];

    // Read port only moves when the output pipeline advances
    always_ff @(posedge ing_bus) begin
        if (wr_en) begin
            data_mem[wr_addr] <= wr_data;
        end
        if (rd_en) begin
            rd_data <= data_mem[rd_addr];
        end
    end

    always_ff @(posedge ing_bus) begin
        if (attr_wr_en) begin
            attr_mem[attr_wr_addr] <= attr_wr_data;
        end
    end

    // Polling looks at the attribute in the same cycle
    assign attr_rd_data = attr_mem[attr_rd_addr];

endmodule

//--- rtl/ingress_stream_pkg.sv
//////////////////////////////////////////////////////////////////////
// Ingress stream beats and attributes
//////////////////////////////////////////////////////////////////////

package ingress_stream_pkg;

    // Input beat from one port
    typedef struct packed {
        ingress_geometry_pkg::data_t data;
        ingress_geometry_pkg::keep_t keep;
        logic                        last;
    } in_beat_t;

    typedef in_beat_t [ingress_geometry_pkg::num_ports-1:0] in_beat_arr_t;

    // Ingress metadata attached to every output beat
    typedef struct packed {
        ingress_geometry_pkg::port_id_t  port;
        ingress_geometry_pkg::byte_len_t byte_len;
    } ing_meta_t;

    typedef struct packed {
        ingress_geometry_pkg::data_t data;
        ingress_geometry_pkg::keep_t keep;
        logic                        last;
        ing_meta_t                   meta;
    } out_beat_t;

    // Committed packet: pointer to its last word and its byte length
    typedef struct packed {
        ingress_geometry_pkg::word_ptr_t last_ptr;
        ingress_geometry_pkg::byte_len_t byte_len;
    } pkt_attr_t;

endpackage

//--- rtl/ingress_geometry_pkg.sv
//////////////////////////////////////////////////////////////////////
// Ingress buffer geometry
//////////////////////////////////////////////////////////////////////

package ingress_geometry_pkg;

    // Port count and partition sizes
    localparam int num_ports      = 4;
    localparam int data_bytes     = 8;
    localparam int words_per_port = 16;
    localparam int pkts_per_port  = 8;

    typedef logic [$clog2(num_ports)-1:0]      port_id_t;
    typedef logic [$clog2(words_per_port)-1:0] word_ptr_t;
    typedef logic [5:0]                        word_addr_t;
    typedef logic [$clog2(pkts_per_port)-1:0]  pkt_ptr_t;
    typedef logic [4:0]                        pkt_addr_t;
    typedef logic [7:0]                        byte_len_t;
    typedef logic [4:0]                        word_cnt_t;
    typedef logic [data_bytes-1:0]             keep_t;
    typedef logic [data_bytes*8-1:0]           data_t;

    // One pointer per port
    typedef word_ptr_t [num_ports-1:0] word_ptr_arr_t;
    typedef pkt_ptr_t  [num_ports-1:0] pkt_ptr_arr_t;

endpackage
